// ==== all.f ====
src/vmd_op_pkg.sv
src/vmd_stream_pkg.sv
src/vmd_mul_pipe.sv
src/vmd_serial_div.sv
src/vmd_rsp_arb.sv
src/vmd_muldiv_unit.sv
dv/vmd_props.sv
dv/vmd_checker.sv
dv/vmd_tb.sv

// ==== dv/vmd_checker.sv ====
//########################################
// Response checker
// Records accepted requests by uuid,
// predicts each lane with a reference
// model and compares every response
//########################################

`timescale 1ns/100ps

module vmd_checker #(
    parameter int NUM_LANES = 4
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         req_valid,
    input  logic                                         req_ready,
    input  vmd_stream_pkg::vmd_req_ctl_t                 req,
    input  logic [NUM_LANES-1:0]                         req_tmask,
    input  logic [NUM_LANES-1:0][vmd_op_pkg::XLEN-1:0]   req_a,
    input  logic [NUM_LANES-1:0][vmd_op_pkg::XLEN-1:0]   req_b,
    input  logic                                         rsp_valid,
    input  logic                                         rsp_ready,
    input  vmd_stream_pkg::vmd_tag_t                     rsp_tag,
    input  logic [NUM_LANES-1:0]                         rsp_tmask,
    input  logic [NUM_LANES-1:0][vmd_op_pkg::XLEN-1:0]   rsp_data,
    input  int                                           extra_errors,
    input  logic                                         finish_req,
    output logic                                         report_ready,
    output int                                           outstanding,
    output int                                           total_errors
);
    import vmd_op_pkg::*;
    import vmd_stream_pkg::*;

    logic                             pending [256];
    vmd_op_e                          exp_op [256];
    vmd_tag_t                         exp_tag [256];
    logic [NUM_LANES-1:0]             exp_tmask [256];
    logic [NUM_LANES-1:0][XLEN-1:0]   exp_data [256];
    int                               err_count;
    int                               check_count;

    assign total_errors = err_count + extra_errors;

    // RISC-V M-extension result for one lane
    function automatic logic [XLEN-1:0] ref_result(vmd_op_e op, logic [XLEN-1:0] a,
                                                   logic [XLEN-1:0] b);
        logic [63:0]     sa;
        logic [63:0]     sb;
        logic [63:0]     ua;
        logic [63:0]     ub;
        logic [63:0]     prod;
        logic            ovf;
        logic [XLEN-1:0] res;
        sa   = {{32{a[31]}}, a};
        sb   = {{32{b[31]}}, b};
        ua   = {32'b0, a};
        ub   = {32'b0, b};
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        prod = '0;
        case (op)
            OP_MUL: begin
                prod = ua * ub;
                res  = prod[31:0];
            end
            OP_MULH: begin
                prod = sa * sb;
                res  = prod[63:32];
            end
            OP_MULHSU: begin
                prod = sa * ub;
                res  = prod[63:32];
            end
            OP_MULHU: begin
                prod = ua * ub;
                res  = prod[63:32];
            end
            OP_DIV:    res = (b == 0) ? '1 : ovf ? a : 32'($signed(a) / $signed(b));
            OP_DIVU:   res = (b == 0) ? '1 : a / b;
            OP_REM:    res = (b == 0) ? a : ovf ? '0 : 32'($signed(a) % $signed(b));
            default:   res = (b == 0) ? a : a % b;
        endcase
        return res;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            pending[i] = 1'b0;
        end
        err_count    = 0;
        check_count  = 0;
        outstanding  = 0;
        report_ready = 1'b0;
    end

    // Sampled at the falling edge, where every stream signal is settled
    always @(negedge clk) begin
        int u;
        if (!reset && req_valid && req_ready) begin
            u = req.tag.uuid;
            if (pending[u]) begin
                $display("ERROR: request reuses uuid %0d that is still outstanding", u);
                err_count++;
            end
            pending[u]   = 1'b1;
            exp_op[u]    = req.op;
            exp_tag[u]   = req.tag;
            exp_tmask[u] = req_tmask;
            for (int l = 0; l < NUM_LANES; l++) begin
                exp_data[u][l] = ref_result(req.op, req_a[l], req_b[l]);
            end
            outstanding++;
        end
        if (!reset && rsp_valid && rsp_ready) begin
            u = rsp_tag.uuid;
            if (!pending[u]) begin
                $display("ERROR: response with unknown or duplicated uuid %0d", u);
                err_count++;
            end else begin
                check_count++;
                if (rsp_tag !== exp_tag[u]) begin
                    $display("CHECK FAILED %s tag: expected %h actual %h",
                             exp_op[u].name(), exp_tag[u], rsp_tag);
                    err_count++;
                end
                if (rsp_tmask !== exp_tmask[u]) begin
                    $display("CHECK FAILED %s tmask uuid %0d: expected %h actual %h",
                             exp_op[u].name(), u, exp_tmask[u], rsp_tmask);
                    err_count++;
                end
                for (int l = 0; l < NUM_LANES; l++) begin
                    if (rsp_data[l] !== exp_data[u][l]) begin
                        $display("CHECK FAILED %s uuid %0d lane %0d: expected %h actual %h",
                                 exp_op[u].name(), u, l, exp_data[u][l], rsp_data[l]);
                        err_count++;
                    end
                end
                pending[u] = 1'b0;
                outstanding--;
            end
        end
        if (finish_req && !report_ready) begin
            if (outstanding != 0) begin
                $display("ERROR: %0d requests never received a response", outstanding);
                err_count++;
            end
            $display("responses checked: %0d  errors: %0d", check_count,
                     err_count + extra_errors);
            report_ready = 1'b1;
        end
    end

endmodule

// ==== dv/vmd_props.sv ====
//########################################
// Stream properties of the unit
// Reset, output stability and divider
// occupancy assertions
//########################################

`timescale 1ns/100ps

module vmd_props #(
    parameter int NUM_LANES = 4
) (
    input logic                                         clk,
    input logic                                         reset,
    input logic                                         rsp_valid,
    input logic                                         rsp_ready,
    input vmd_stream_pkg::vmd_tag_t                     rsp_tag,
    input logic [NUM_LANES-1:0]                         rsp_tmask,
    input logic [NUM_LANES-1:0][vmd_op_pkg::XLEN-1:0]   rsp_data,
    input logic                                         div_valid,
    input logic                                         div_ready,
    input logic                                         div_out_valid,
    input logic                                         div_out_ready
);
    int   fail_count = 0;
    logic div_in_flight;

    // Set when the divider takes a request, cleared when its result leaves
    always_ff @(posedge clk) begin
        if (reset) begin
            div_in_flight <= 1'b0;
        end else if (div_out_valid && div_out_ready) begin
            div_in_flight <= 1'b0;
        end else if (div_valid && div_ready) begin
            div_in_flight <= 1'b1;
        end
    end

    rsp_low_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !rsp_valid)
        else begin
            fail_count++;
            $error("rsp_valid high during reset");
        end

    rsp_held: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_tag)
                                    && $stable(rsp_tmask) && $stable(rsp_data))
        else begin
            fail_count++;
            $error("response changed while rsp_ready was low");
        end

    div_busy_not_ready: assert property (@(posedge clk) disable iff (reset)
        div_in_flight |-> !div_ready)
        else begin
            fail_count++;
            $error("divider ready while a divide is in flight");
        end

endmodule

// ==== dv/vmd_tb.sv ====
//########################################
// Multiply/divide unit testbench
// Clock, reset, random request stream,
// response back-pressure and timeout
//########################################

`timescale 1ns/100ps

module vmd_tb;
    import vmd_op_pkg::*;
    import vmd_stream_pkg::*;

    localparam int NUM_LANES      = 4;
    localparam int MUL_LATENCY    = 3;
    localparam int NUM_OPS        = 600;
    localparam int MAX_OP_CYCLES  = 60;
    localparam int TIMEOUT_CYCLES = NUM_OPS * MAX_OP_CYCLES + 4000;
    localparam int DRAIN_CYCLES   = 4 * MAX_OP_CYCLES;

    logic                             clk;
    logic                             reset;
    logic                             req_valid;
    logic                             req_ready;
    vmd_req_ctl_t                     req;
    logic [NUM_LANES-1:0]             req_tmask;
    logic [NUM_LANES-1:0][XLEN-1:0]   req_a;
    logic [NUM_LANES-1:0][XLEN-1:0]   req_b;
    logic                             rsp_valid;
    logic                             rsp_ready;
    vmd_tag_t                         rsp_tag;
    logic [NUM_LANES-1:0]             rsp_tmask;
    logic [NUM_LANES-1:0][XLEN-1:0]   rsp_data;
    logic                             finish_req;
    logic                             report_ready;
    int                               outstanding;
    int                               total_errors;
    int                               extra_errors;
    int                               tb_errors;
    int                               cycles;
    logic [31:0]                      rng;
    logic [31:0]                      bp_rng;
    logic [7:0]                       next_uuid;
    logic                             first_mul;
    logic                             first_div;

    vmd_muldiv_unit #(
        .NUM_LANES   (NUM_LANES),
        .MUL_LATENCY (MUL_LATENCY)
    ) dut (.*);

    vmd_checker #(.NUM_LANES(NUM_LANES)) u_checker (.*);

    bind vmd_muldiv_unit vmd_props #(.NUM_LANES(NUM_LANES)) u_props (
        .clk           (clk),
        .reset         (reset),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_tag       (rsp_tag),
        .rsp_tmask     (rsp_tmask),
        .rsp_data      (rsp_data),
        .div_valid     (div_valid),
        .div_ready     (div_ready),
        .div_out_valid (eng_valid[1]),
        .div_out_ready (eng_ready[1])
    );

    // Failed assertions count as errors next to the stimulus checks
    assign extra_errors = tb_errors + dut.u_props.fail_count;

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Extreme values turn up often next to fully random ones
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = next_random();
        case (r[2:0])
            3'd0:    return 32'h0000_0000;
            3'd1:    return 32'hffff_ffff;
            3'd2:    return 32'h8000_0000;
            3'd3:    return 32'h0000_0001;
            default: return next_random();
        endcase
    endfunction

    always #2 clk = ~clk;

    always @(posedge clk) begin
        #0.5;
        bp_rng    = xorshift(bp_rng);
        rsp_ready = bp_rng[0];
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic send_request(input vmd_op_e op, input logic force_ovf);
        logic [31:0] r;
        logic        accepted;
        logic        check_first;
        r = next_random();
        if (r[1:0] == 2'd0) begin
            repeat (r[3:2] + 1) begin
                @(posedge clk);
                #0.5;
            end
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            req_a[l] = pick_operand();
            r = next_random();
            req_b[l] = (op_is_div(op) && (r % 10 == 0)) ? 32'h0 : pick_operand();
        end
        if (force_ovf) begin
            req_a[0] = 32'h8000_0000;
            req_b[0] = 32'hffff_ffff;
        end
        r = next_random();
        req.op          = op;
        req.tag.uuid    = next_uuid;
        req.tag.rd      = r[4:0];
        req.tag.wb      = r[5];
        req.tag.sop     = r[6];
        req.tag.eop     = r[7];
        req_tmask       = r[11:8];
        req_valid       = 1'b1;
        next_uuid++;
        check_first = op_is_div(op) ? first_div : first_mul;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready;
            if (check_first && !accepted) begin
                $display("ERROR: req_ready low for the first %s request", op.name());
                tb_errors++;
            end
            check_first = 1'b0;
            @(posedge clk);
            #0.5;
        end
        first_mul = first_mul && op_is_div(op);
        first_div = first_div && !op_is_div(op);
        req_valid = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        int          drain;
        clk        = 1'b0;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        req_tmask  = '0;
        req_a      = '0;
        req_b      = '0;
        rsp_ready  = 1'b1;
        finish_req = 1'b0;
        tb_errors  = 0;
        cycles     = 0;
        rng        = 32'hf3cb479e;
        bp_rng     = xorshift(32'hf3cb479e);
        next_uuid  = '0;
        first_mul  = 1'b1;
        first_div  = 1'b1;
        repeat (2) @(posedge clk);
        #0.5;
        reset = 1'b0;
        // Nothing may come out before any request went in
        repeat (3) begin
            @(negedge clk);
            if (rsp_valid) begin
                $display("ERROR: rsp_valid high after reset with no request sent");
                tb_errors++;
            end
        end
        @(posedge clk);
        #0.5;
        for (int i = 0; i < 150; i++) begin
            r = next_random();
            send_request(vmd_op_e'({1'b0, r[1:0]}), 1'b0);
        end
        for (int i = 0; i < 150; i++) begin
            r = next_random();
            if (i % 10 == 5) begin
                send_request(r[0] ? OP_REM : OP_DIV, 1'b1);
            end else begin
                send_request(vmd_op_e'({1'b1, r[1:0]}), 1'b0);
            end
        end
        for (int i = 0; i < 300; i++) begin
            r = next_random();
            send_request(vmd_op_e'(r[2:0]), 1'b0);
        end
        // Give the last responses time to drain, then let the checker report
        drain = 0;
        while (outstanding != 0 && drain < DRAIN_CYCLES) begin
            @(posedge clk);
            drain++;
        end
        finish_req = 1'b1;
        while (!report_ready) begin
            @(posedge clk);
        end
        if (total_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the multiply/divide unit testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module vmd_tb --Mdir obj_dir -o vmd_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/vmd_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== src/vmd_mul_pipe.sv ====
//########################################
// Multiply pipeline
// Lane-parallel signed multiplier with a
// stallable control shift register and
// upper/lower half selection at the end
//########################################

`timescale 1ns/100ps

module vmd_mul_pipe #(
    parameter int NUM_LANES   = 4,
    parameter int MUL_LATENCY = 3
) (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           in_valid,
    output logic                                           in_ready,
    input  vmd_stream_pkg::vmd_tag_t                       in_tag,
    input  logic [NUM_LANES-1:0]                           in_tmask,
    input  logic                                           in_high,
    input  logic [NUM_LANES-1:0][vmd_op_pkg::XLEN:0]       in_a,
    input  logic [NUM_LANES-1:0][vmd_op_pkg::XLEN:0]       in_b,
    output logic                                           out_valid,
    input  logic                                           out_ready,
    output vmd_stream_pkg::vmd_tag_t                       out_tag,
    output logic [NUM_LANES-1:0]                           out_tmask,
    output logic [NUM_LANES-1:0][vmd_op_pkg::XLEN-1:0]     out_data
);
    import vmd_op_pkg::*;
    import vmd_stream_pkg::*;

    typedef struct packed {
        vmd_tag_t             tag;
        logic [NUM_LANES-1:0] tmask;
        logic                 high;
    } stage_ctl_t;

    localparam int LAST = MUL_LATENCY - 1;

    logic                                 enable;
    logic [MUL_LATENCY-1:0]               valid_q;
    stage_ctl_t                           ctl_q [MUL_LATENCY];
    logic [NUM_LANES-1:0][2*XLEN+1:0]     prod_in;
    logic [NUM_LANES-1:0][2*XLEN+1:0]     prod_q [MUL_LATENCY];

    // The whole pipe holds when its last stage waits on the consumer
    assign enable   = out_ready || !valid_q[LAST];
    assign in_ready = enable;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            prod_in[i] = $signed(in_a[i]) * $signed(in_b[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q[0] <= in_valid;
            for (int k = 1; k < MUL_LATENCY; k++) begin
                valid_q[k] <= valid_q[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            ctl_q[0]  <= '{tag: in_tag, tmask: in_tmask, high: in_high};
            prod_q[0] <= prod_in;
            for (int k = 1; k < MUL_LATENCY; k++) begin
                ctl_q[k]  <= ctl_q[k-1];
                prod_q[k] <= prod_q[k-1];
            end
        end
    end

    assign out_valid = valid_q[LAST];
    assign out_tag   = ctl_q[LAST].tag;
    assign out_tmask = ctl_q[LAST].tmask;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (ctl_q[LAST].high) begin
                out_data[i] = prod_q[LAST][i][2*XLEN-1:XLEN];
            end else begin
                out_data[i] = prod_q[LAST][i][XLEN-1:0];
            end
        end
    end

endmodule

// ==== src/vmd_muldiv_unit.sv ====
//########################################
// Integer multiply/divide unit
// Decodes M-extension ops, steers each
// request to the multiplier or divider
// and merges both result streams
//########################################

`timescale 1ns/100ps

module vmd_muldiv_unit #(
    parameter int NUM_LANES   = 4,
    parameter int MUL_LATENCY = 3
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         req_valid,
    output logic                                         req_ready,
    input  vmd_stream_pkg::vmd_req_ctl_t                 req,
    input  logic [NUM_LANES-1:0]                         req_tmask,
    input  logic [NUM_LANES-1:0][vmd_op_pkg::XLEN-1:0]   req_a,
    input  logic [NUM_LANES-1:0][vmd_op_pkg::XLEN-1:0]   req_b,
    output logic                                         rsp_valid,
    input  logic                                         rsp_ready,
    output vmd_stream_pkg::vmd_tag_t                     rsp_tag,
    output logic [NUM_LANES-1:0]                         rsp_tmask,
    output logic [NUM_LANES-1:0][vmd_op_pkg::XLEN-1:0]   rsp_data
);
    import vmd_op_pkg::*;
    import vmd_stream_pkg::*;

    logic                             is_div;
    logic                             mul_valid;
    logic                             mul_ready;
    logic                             div_valid;
    logic                             div_ready;
    logic [NUM_LANES-1:0][XLEN:0]     mul_a;
    logic [NUM_LANES-1:0][XLEN:0]     mul_b;
    logic [1:0]                       eng_valid;
    logic [1:0]                       eng_ready;
    vmd_tag_t                         eng_tag [2];
    logic [NUM_LANES-1:0]             eng_tmask [2];
    logic [NUM_LANES-1:0][XLEN-1:0]   eng_data [2];

    assign is_div    = op_is_div(req.op);
    assign mul_valid = req_valid && !is_div;
    assign div_valid = req_valid && is_div;
    assign req_ready = is_div ? div_ready : mul_ready;

    // One extra bit lets a single signed multiplier cover every variant
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            mul_a[i] = {op_is_signed_a(req.op) && req_a[i][XLEN-1], req_a[i]};
            mul_b[i] = {op_is_signed_b(req.op) && req_b[i][XLEN-1], req_b[i]};
        end
    end

    vmd_mul_pipe #(
        .NUM_LANES   (NUM_LANES),
        .MUL_LATENCY (MUL_LATENCY)
    ) u_mul (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mul_valid),
        .in_ready  (mul_ready),
        .in_tag    (req.tag),
        .in_tmask  (req_tmask),
        .in_high   (op_is_high(req.op)),
        .in_a      (mul_a),
        .in_b      (mul_b),
        .out_valid (eng_valid[0]),
        .out_ready (eng_ready[0]),
        .out_tag   (eng_tag[0]),
        .out_tmask (eng_tmask[0]),
        .out_data  (eng_data[0])
    );

    vmd_serial_div #(
        .NUM_LANES (NUM_LANES)
    ) u_div (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (div_valid),
        .in_ready  (div_ready),
        .in_tag    (req.tag),
        .in_tmask  (req_tmask),
        .in_signed (op_is_signed_a(req.op)),
        .in_rem    (op_is_rem(req.op)),
        .in_n      (req_a),
        .in_d      (req_b),
        .out_valid (eng_valid[1]),
        .out_ready (eng_ready[1]),
        .out_tag   (eng_tag[1]),
        .out_tmask (eng_tmask[1]),
        .out_data  (eng_data[1])
    );

    vmd_rsp_arb #(
        .NUM_LANES (NUM_LANES)
    ) u_arb (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (eng_valid),
        .in_ready  (eng_ready),
        .in_tag    (eng_tag),
        .in_tmask  (eng_tmask),
        .in_data   (eng_data),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_tag   (rsp_tag),
        .out_tmask (rsp_tmask),
        .out_data  (rsp_data)
    );

endmodule

// ==== src/vmd_op_pkg.sv ====
//########################################
// Multiply/divide operation definitions
// Lane data width, the M-extension
// operation codes and the small decode
// helpers shared by RTL and checker
//########################################

package vmd_op_pkg;

    localparam int XLEN = 32;

    // Bit 2 set marks the divide class
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } vmd_op_e;

    function automatic logic op_is_div(vmd_op_e op);
        return op[2];
    endfunction

    function automatic logic op_is_signed_a(vmd_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_DIV, OP_REM};
    endfunction

    function automatic logic op_is_signed_b(vmd_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_DIV, OP_REM};
    endfunction

    function automatic logic op_is_high(vmd_op_e op);
        return op inside {OP_MULH, OP_MULHSU, OP_MULHU};
    endfunction

    function automatic logic op_is_rem(vmd_op_e op);
        return op inside {OP_REM, OP_REMU};
    endfunction

endpackage

// ==== src/vmd_rsp_arb.sv ====
//########################################
// Response arbiter
// Two-input round-robin stream arbiter
// with one registered output stage
//########################################

`timescale 1ns/100ps

module vmd_rsp_arb #(
    parameter int NUM_LANES = 4
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [1:0]                                   in_valid,
    output logic [1:0]                                   in_ready,
    input  vmd_stream_pkg::vmd_tag_t                     in_tag [2],
    input  logic [NUM_LANES-1:0]                         in_tmask [2],
    input  logic [NUM_LANES-1:0][vmd_op_pkg::XLEN-1:0]   in_data [2],
    output logic                                         out_valid,
    input  logic                                         out_ready,
    output vmd_stream_pkg::vmd_tag_t                     out_tag,
    output logic [NUM_LANES-1:0]                         out_tmask,
    output logic [NUM_LANES-1:0][vmd_op_pkg::XLEN-1:0]   out_data
);
    import vmd_op_pkg::*;
    import vmd_stream_pkg::*;

    logic                             prio;
    logic                             gnt;
    logic                             load;
    logic                             take;
    logic                             valid_q;
    vmd_rsp_ctl_t                     ctl_q;
    logic [NUM_LANES-1:0]             tmask_q;
    logic [NUM_LANES-1:0][XLEN-1:0]   data_q;

    // The register can load when it is empty or drains this cycle
    assign load = !valid_q || out_ready;
    assign take = load && (|in_valid);

    always_comb begin
        gnt = (in_valid[0] && in_valid[1]) ? prio : in_valid[1];
        in_ready = '0;
        if (take) begin
            in_ready[gnt] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            prio    <= 1'b0;
        end else begin
            if (load) begin
                valid_q <= |in_valid;
            end
            if (take) begin
                prio <= !gnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ctl_q.tag <= in_tag[gnt];
            tmask_q   <= in_tmask[gnt];
            data_q    <= in_data[gnt];
        end
    end

    assign out_valid = valid_q;
    assign out_tag   = ctl_q.tag;
    assign out_tmask = tmask_q;
    assign out_data  = data_q;

endmodule

// ==== src/vmd_serial_div.sv ====
//########################################
// Bit-serial divider
// Lane-parallel restoring division, one
// bit per cycle, with its own idle/busy/
// done control and the RISC-V corner cases
//########################################

`timescale 1ns/100ps

module vmd_serial_div #(
    parameter int NUM_LANES = 4
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         in_valid,
    output logic                                         in_ready,
    input  vmd_stream_pkg::vmd_tag_t                     in_tag,
    input  logic [NUM_LANES-1:0]                         in_tmask,
    input  logic                                         in_signed,
    input  logic                                         in_rem,
    input  logic [NUM_LANES-1:0][vmd_op_pkg::XLEN-1:0]   in_n,
    input  logic [NUM_LANES-1:0][vmd_op_pkg::XLEN-1:0]   in_d,
    output logic                                         out_valid,
    input  logic                                         out_ready,
    output vmd_stream_pkg::vmd_tag_t                     out_tag,
    output logic [NUM_LANES-1:0]                         out_tmask,
    output logic [NUM_LANES-1:0][vmd_op_pkg::XLEN-1:0]   out_data
);
    import vmd_op_pkg::*;
    import vmd_stream_pkg::*;

    localparam int CNT_W = $clog2(XLEN);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_e;

    // Per-lane facts caught at acceptance
    typedef struct packed {
        logic dz;
        logic ovf;
        logic neg_q;
        logic neg_r;
    } lane_flags_t;

    div_state_e                        state;
    logic [CNT_W-1:0]                  step;
    logic                              accept;
    vmd_tag_t                          tag_q;
    logic [NUM_LANES-1:0]              tmask_q;
    logic                              rem_sel_q;
    lane_flags_t [NUM_LANES-1:0]       flags_in;
    lane_flags_t [NUM_LANES-1:0]       flags_q;
    logic [NUM_LANES-1:0][XLEN-1:0]    mag_n;
    logic [NUM_LANES-1:0][XLEN-1:0]    mag_d;
    logic [NUM_LANES-1:0][XLEN-1:0]    quo_q;
    logic [NUM_LANES-1:0][XLEN-1:0]    rem_q;
    logic [NUM_LANES-1:0][XLEN-1:0]    den_q;
    logic [NUM_LANES-1:0][XLEN-1:0]    quo_nxt;
    logic [NUM_LANES-1:0][XLEN-1:0]    rem_nxt;

    assign in_ready  = (state == DIV_IDLE);
    assign accept    = in_valid && in_ready;
    assign out_valid = (state == DIV_DONE);
    assign out_tag   = tag_q;
    assign out_tmask = tmask_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DIV_IDLE;
            step  <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    step <= '0;
                    if (accept) begin
                        state <= DIV_BUSY;
                    end
                end
                DIV_BUSY: begin
                    step <= step + 1'b1;
                    if (step == CNT_W'(XLEN - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                default: begin
                    if (out_ready) begin
                        state <= DIV_IDLE;
                    end
                end
            endcase
        end
    end

    // Operand magnitudes and the sign/corner flags
    always_comb begin
        logic n_neg;
        logic d_neg;
        for (int i = 0; i < NUM_LANES; i++) begin
            n_neg = in_signed && in_n[i][XLEN-1];
            d_neg = in_signed && in_d[i][XLEN-1];
            mag_n[i] = n_neg ? -in_n[i] : in_n[i];
            mag_d[i] = d_neg ? -in_d[i] : in_d[i];
            flags_in[i].dz    = (in_d[i] == '0);
            flags_in[i].ovf   = in_signed && (in_n[i] == {1'b1, {(XLEN-1){1'b0}}})
                                && (in_d[i] == '1);
            flags_in[i].neg_q = n_neg ^ d_neg;
            flags_in[i].neg_r = n_neg;
        end
    end

    // One restoring step per lane, the dividend shifts out of quo_q
    always_comb begin
        logic [XLEN:0] shifted;
        logic [XLEN:0] diff;
        for (int i = 0; i < NUM_LANES; i++) begin
            shifted = {rem_q[i], quo_q[i][XLEN-1]};
            diff    = shifted - {1'b0, den_q[i]};
            if (!diff[XLEN]) begin
                rem_nxt[i] = diff[XLEN-1:0];
                quo_nxt[i] = {quo_q[i][XLEN-2:0], 1'b1};
            end else begin
                rem_nxt[i] = shifted[XLEN-1:0];
                quo_nxt[i] = {quo_q[i][XLEN-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q     <= in_tag;
            tmask_q   <= in_tmask;
            rem_sel_q <= in_rem;
            flags_q   <= flags_in;
            quo_q     <= mag_n;
            den_q     <= mag_d;
            rem_q     <= '0;
        end else if (state == DIV_BUSY) begin
            quo_q <= quo_nxt;
            rem_q <= rem_nxt;
        end
    end

    // Sign fix-up, then the forced results of the two corner cases
    always_comb begin
        logic [XLEN-1:0] q_fix;
        logic [XLEN-1:0] r_fix;
        for (int i = 0; i < NUM_LANES; i++) begin
            q_fix = flags_q[i].neg_q ? -quo_q[i] : quo_q[i];
            r_fix = flags_q[i].neg_r ? -rem_q[i] : rem_q[i];
            if (flags_q[i].dz) begin
                q_fix = '1;
            end
            if (flags_q[i].ovf) begin
                q_fix = {1'b1, {(XLEN-1){1'b0}}};
                r_fix = '0;
            end
            out_data[i] = rem_sel_q ? r_fix : q_fix;
        end
    end

endmodule

// ==== src/vmd_stream_pkg.sv ====
//########################################
// Request and response stream types
// Bookkeeping tag and the control
// structs carried by the unit's streams
//########################################

package vmd_stream_pkg;

    // Travels unchanged from request to response
    typedef struct packed {
        logic [7:0] uuid;
        logic [4:0] rd;
        logic       wb;
        logic       sop;
        logic       eop;
    } vmd_tag_t;

    typedef struct packed {
        vmd_op_pkg::vmd_op_e op;
        vmd_tag_t            tag;
    } vmd_req_ctl_t;

    // The thread mask goes beside this struct on its own port,
    // its width is set by the lane count of the instance
    typedef struct packed {
        vmd_tag_t tag;
    } vmd_rsp_ctl_t;

endpackage
